// ==== design/pinmux_settings.svh ====
`ifndef PINMUX_SETTINGS_SVH
`define PINMUX_SETTINGS_SVH

// Port and bus widths
`define GPIO_WIDTH      8
`define REG_AW          8
`define REG_DW          32

// Tick generator, ten 100 ns cycles per us at reset
`define PULSE_CNT_W     10
`define PULSE_1US_RST   9
`define US_PER_MS       1000

// PWM channels and the pads they own
`define PWM_CNT_W       16
`define PWM_CHANNELS    2
`define PWM0_PAD        4
`define PWM1_PAD        5

// Register map, one word each
`define ADDR_GPIO_DIR          8'h00
`define ADDR_GPIO_OUT          8'h04
`define ADDR_GPIO_IN           8'h08
`define ADDR_GPIO_INT_STAT     8'h0C
`define ADDR_GPIO_POSEDGE_SEL  8'h10
`define ADDR_GPIO_NEGEDGE_SEL  8'h14
`define ADDR_MULTI_FUNC_SEL    8'h18
`define ADDR_PULSE_1US         8'h1C
`define ADDR_PWM0              8'h20
`define ADDR_PWM1              8'h24

`endif

// ==== design/pinmux_pkg.sv ====
`include "pinmux_settings.svh"

package pinmux_pkg;

  // One bit per GPIO pin / pad
  typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;

  // --------------------------------------------------
  // PWM configuration word
  // --------------------------------------------------

  // Phase lengths in ms ticks
  typedef struct packed {
    logic [`PWM_CNT_W-1:0] high;  // Upper half
    logic [`PWM_CNT_W-1:0] low;   // Lower half
  } pwm_phase_t;

  // Bus view and field view of the same word
  typedef union packed {
    logic [`REG_DW-1:0] raw;
    pwm_phase_t         fld;
  } pwm_cfg_u;

endpackage

// ==== design/pinmux_reg.sv ====
`timescale 1ns/1ps
`include "pinmux_settings.svh"

module pinmux_reg (
  input  logic                                    mclk,
  input  logic                                    reset_i,
  // Register bus
  input  logic                                    reg_cs_i,
  input  logic                                    reg_wr_i,
  input  logic [`REG_AW-1:0]                      reg_addr_i,
  input  logic [`REG_DW-1:0]                      reg_wdata_i,
  input  logic [`REG_DW/8-1:0]                    reg_be_i,
  output logic [`REG_DW-1:0]                      reg_rdata_o,
  output logic                                    reg_ack_o,
  // GPIO status inputs
  input  pinmux_pkg::gpio_word_t                  gpio_in_i,
  input  pinmux_pkg::gpio_word_t                  gpio_int_event_i,
  // Configuration outputs
  output pinmux_pkg::gpio_word_t                  cfg_gpio_dir_o,
  output pinmux_pkg::gpio_word_t                  cfg_gpio_out_o,
  output pinmux_pkg::gpio_word_t                  cfg_posedge_sel_o,
  output pinmux_pkg::gpio_word_t                  cfg_negedge_sel_o,
  output logic [`PWM_CHANNELS-1:0]                cfg_pwm_enb_o,
  output pinmux_pkg::pwm_cfg_u [`PWM_CHANNELS-1:0] cfg_pwm_o,
  output logic [`PULSE_CNT_W-1:0]                 cfg_pulse_1us_o,
  output logic                                    pulse_cfg_update_o,
  output logic                                    irq_o
);

  import pinmux_pkg::*;

  logic               reg_hit;    // New access, not yet acked
  logic               wr_en;
  gpio_word_t         int_stat;   // Edge interrupt status
  gpio_word_t         int_clr;    // Write-one-to-clear mask
  logic [`REG_DW-1:0] rdata_nxt;

  // Merge write data into a word by byte lane
  function automatic logic [`REG_DW-1:0] be_merge(
    input logic [`REG_DW-1:0]   cur,
    input logic [`REG_DW-1:0]   wdata,
    input logic [`REG_DW/8-1:0] be
  );
    logic [`REG_DW-1:0] res;
    res = cur;
    for (int b = 0; b < `REG_DW/8; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  assign reg_hit = reg_cs_i && !reg_ack_o;
  assign wr_en   = reg_hit && reg_wr_i;

  // --------------------------------------------------
  // Configuration registers
  // --------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      cfg_gpio_dir_o    <= '0;
      cfg_gpio_out_o    <= '0;
      cfg_posedge_sel_o <= '0;
      cfg_negedge_sel_o <= '0;
      cfg_pwm_enb_o     <= '0;
      cfg_pwm_o         <= '0;
      cfg_pulse_1us_o   <= `PULSE_CNT_W'(`PULSE_1US_RST);
    end else if (wr_en) begin
      case (reg_addr_i)
        `ADDR_GPIO_DIR:
          cfg_gpio_dir_o <= gpio_word_t'(be_merge(`REG_DW'(cfg_gpio_dir_o),
                                                  reg_wdata_i, reg_be_i));
        `ADDR_GPIO_OUT:
          cfg_gpio_out_o <= gpio_word_t'(be_merge(`REG_DW'(cfg_gpio_out_o),
                                                  reg_wdata_i, reg_be_i));
        `ADDR_GPIO_POSEDGE_SEL:
          cfg_posedge_sel_o <= gpio_word_t'(be_merge(`REG_DW'(cfg_posedge_sel_o),
                                                     reg_wdata_i, reg_be_i));
        `ADDR_GPIO_NEGEDGE_SEL:
          cfg_negedge_sel_o <= gpio_word_t'(be_merge(`REG_DW'(cfg_negedge_sel_o),
                                                     reg_wdata_i, reg_be_i));
        `ADDR_MULTI_FUNC_SEL:
          cfg_pwm_enb_o <= `PWM_CHANNELS'(be_merge(`REG_DW'(cfg_pwm_enb_o),
                                                   reg_wdata_i, reg_be_i));
        `ADDR_PULSE_1US:
          cfg_pulse_1us_o <= `PULSE_CNT_W'(be_merge(`REG_DW'(cfg_pulse_1us_o),
                                                    reg_wdata_i, reg_be_i));
        `ADDR_PWM0:
          cfg_pwm_o[0].raw <= be_merge(cfg_pwm_o[0].raw, reg_wdata_i, reg_be_i);
        `ADDR_PWM1:
          cfg_pwm_o[1].raw <= be_merge(cfg_pwm_o[1].raw, reg_wdata_i, reg_be_i);
        default: ;
      endcase
    end
  end

  // Read mux, unmapped words read zero
  always_comb begin
    case (reg_addr_i)
      `ADDR_GPIO_DIR:         rdata_nxt = `REG_DW'(cfg_gpio_dir_o);
      `ADDR_GPIO_OUT:         rdata_nxt = `REG_DW'(cfg_gpio_out_o);
      `ADDR_GPIO_IN:          rdata_nxt = `REG_DW'(gpio_in_i);
      `ADDR_GPIO_INT_STAT:    rdata_nxt = `REG_DW'(int_stat);
      `ADDR_GPIO_POSEDGE_SEL: rdata_nxt = `REG_DW'(cfg_posedge_sel_o);
      `ADDR_GPIO_NEGEDGE_SEL: rdata_nxt = `REG_DW'(cfg_negedge_sel_o);
      `ADDR_MULTI_FUNC_SEL:   rdata_nxt = `REG_DW'(cfg_pwm_enb_o);
      `ADDR_PULSE_1US:        rdata_nxt = `REG_DW'(cfg_pulse_1us_o);
      `ADDR_PWM0:             rdata_nxt = cfg_pwm_o[0].raw;
      `ADDR_PWM1:             rdata_nxt = cfg_pwm_o[1].raw;
      default:                rdata_nxt = '0;
    endcase
  end

  // --------------------------------------------------
  // Acknowledge, read data, tick restart
  // --------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      reg_ack_o          <= 1'b0;
      pulse_cfg_update_o <= 1'b0;
    end else begin
      reg_ack_o          <= reg_hit;
      // High in the ack cycle, when the new count is already loaded
      pulse_cfg_update_o <= wr_en && (reg_addr_i == `ADDR_PULSE_1US);
    end
  end

  always_ff @(posedge mclk) begin
    if (reg_hit) reg_rdata_o <= rdata_nxt;
  end

  // Only byte 0 carries status bits
  assign int_clr = (wr_en && (reg_addr_i == `ADDR_GPIO_INT_STAT) && reg_be_i[0]) ?
                   reg_wdata_i[`GPIO_WIDTH-1:0] : '0;

  // Status and interrupt, a new event beats the clear
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      int_stat <= '0;
      irq_o    <= 1'b0;
    end else begin
      int_stat <= (int_stat & ~int_clr) | gpio_int_event_i;
      irq_o    <= |int_stat;
    end
  end

endmodule

// ==== design/tick_gen.sv ====
`timescale 1ns/1ps
`include "pinmux_settings.svh"

module tick_gen (
  input  logic                    mclk,
  input  logic                    reset_i,
  input  logic [`PULSE_CNT_W-1:0] cfg_pulse_1us_i,
  input  logic                    cfg_update_i,
  output logic                    pulse_1us_o,
  output logic                    pulse_1ms_o
);

  localparam int MS_CNT_W = $clog2(`US_PER_MS);

  logic [`PULSE_CNT_W-1:0] us_cnt;   // Cycles left in this us
  logic [MS_CNT_W-1:0]     ms_cnt;   // us strobes left in this ms
  logic                    us_done;

  assign us_done = (us_cnt == '0);

  // --------------------------------------------------
  // 1 us down-counter, period cfg + 1 cycles
  // --------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i || cfg_update_i) begin
      us_cnt      <= cfg_pulse_1us_i;
      pulse_1us_o <= 1'b0;
    end else begin
      pulse_1us_o <= us_done;
      if (us_done) us_cnt <= cfg_pulse_1us_i;
      else         us_cnt <= us_cnt - 1'b1;
    end
  end

  // --------------------------------------------------
  // 1 ms strobe, lined up with the matching us strobe
  // --------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i || cfg_update_i) begin
      ms_cnt      <= MS_CNT_W'(`US_PER_MS - 1);
      pulse_1ms_o <= 1'b0;
    end else begin
      pulse_1ms_o <= us_done && (ms_cnt == '0);
      if (us_done) begin
        if (ms_cnt == '0) ms_cnt <= MS_CNT_W'(`US_PER_MS - 1);
        else              ms_cnt <= ms_cnt - 1'b1;
      end
    end
  end

endmodule

// ==== design/gpio_intr_gen.sv ====
`timescale 1ns/1ps
`include "pinmux_settings.svh"

module gpio_intr_gen (
  input  logic                   mclk,
  input  logic                   reset_i,
  input  pinmux_pkg::gpio_word_t pad_in_i,
  input  pinmux_pkg::gpio_word_t cfg_gpio_dir_i,
  input  pinmux_pkg::gpio_word_t cfg_gpio_out_i,
  input  pinmux_pkg::gpio_word_t cfg_posedge_sel_i,
  input  pinmux_pkg::gpio_word_t cfg_negedge_sel_i,
  output pinmux_pkg::gpio_word_t gpio_in_o,
  output pinmux_pkg::gpio_word_t gpio_int_event_o
);

  import pinmux_pkg::*;

  gpio_word_t watched;     // Value each pin is watched on
  gpio_word_t watched_q;   // Same word one cycle back
  gpio_word_t rise;
  gpio_word_t fall;

  // Output pins watch their own drive, input pins the pad
  assign watched = (cfg_gpio_dir_i & cfg_gpio_out_i) | (~cfg_gpio_dir_i & gpio_in_o);

  // Pad sample and history
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      gpio_in_o <= '0;
      watched_q <= '0;
    end else begin
      gpio_in_o <= pad_in_i;
      watched_q <= watched;
    end
  end

  // --------------------------------------------------
  // Edge detect, gated by the select words
  // --------------------------------------------------
  assign rise = watched & ~watched_q;
  assign fall = ~watched & watched_q;

  // One cycle wide, since history catches up next clock
  assign gpio_int_event_o = (rise & cfg_posedge_sel_i) | (fall & cfg_negedge_sel_i);

endmodule

// ==== design/pwm.sv ====
`timescale 1ns/1ps
`include "pinmux_settings.svh"

module pwm (
  input  logic                 mclk,
  input  logic                 reset_i,
  input  logic                 pulse_1ms_i,
  input  logic                 cfg_enb_i,
  input  pinmux_pkg::pwm_cfg_u cfg_i,
  output logic                 waveform_o
);

  logic                  running;     // Set once the first high phase starts
  logic [`PWM_CNT_W-1:0] phase_cnt;   // ms ticks seen in this phase
  logic [`PWM_CNT_W-1:0] phase_lim;
  logic [`PWM_CNT_W-1:0] phase_last;
  logic                  phase_end;

  // Length of the phase in progress
  assign phase_lim = waveform_o ? cfg_i.fld.high : cfg_i.fld.low;

  // Zero length acts as one tick
  assign phase_last = (phase_lim == '0) ? '0 : phase_lim - 1'b1;
  assign phase_end  = (phase_cnt >= phase_last);

  // --------------------------------------------------
  // Phase sequencer
  // --------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i || !cfg_enb_i) begin
      running    <= 1'b0;
      waveform_o <= 1'b0;
      phase_cnt  <= '0;
    end else if (!running) begin
      // Enable starts with the high phase
      running    <= 1'b1;
      waveform_o <= 1'b1;
      phase_cnt  <= '0;
    end else if (pulse_1ms_i) begin
      if (phase_end) begin
        waveform_o <= ~waveform_o;
        phase_cnt  <= '0;
      end else begin
        phase_cnt  <= phase_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== design/pad_mux.sv ====
`timescale 1ns/1ps
`include "pinmux_settings.svh"

module pad_mux (
  input  logic [`PWM_CHANNELS-1:0] pwm_wfm_i,
  input  logic [`PWM_CHANNELS-1:0] cfg_pwm_enb_i,
  input  pinmux_pkg::gpio_word_t   cfg_gpio_dir_i,
  input  pinmux_pkg::gpio_word_t   cfg_gpio_out_i,
  output pinmux_pkg::gpio_word_t   pad_out_o,
  output pinmux_pkg::gpio_word_t   pad_oen_o
);

  // Pad owned by each PWM channel
  localparam int PWM_PAD [`PWM_CHANNELS] = '{`PWM0_PAD, `PWM1_PAD};

  // --------------------------------------------------
  // Pin map
  // --------------------------------------------------
  always_comb begin
    // Lowest priority, GPIO by direction bit
    for (int p = 0; p < `GPIO_WIDTH; p++) begin
      if (cfg_gpio_dir_i[p]) begin
        pad_out_o[p] = cfg_gpio_out_i[p];
        pad_oen_o[p] = 1'b0;
      end else begin
        // Undriven pad stays an input
        pad_out_o[p] = 1'b0;
        pad_oen_o[p] = 1'b1;
      end
    end

    // PWM takes its pad ahead of GPIO
    for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
      if (cfg_pwm_enb_i[ch]) begin
        pad_out_o[PWM_PAD[ch]] = pwm_wfm_i[ch];
        pad_oen_o[PWM_PAD[ch]] = 1'b0;
      end
    end
  end

endmodule

// ==== design/pinmux_top.sv ====
`timescale 1ns/1ps
`include "pinmux_settings.svh"

module pinmux_top (
  input  logic                   mclk,
  input  logic                   reset_i,
  // Register bus
  input  logic                   reg_cs_i,
  input  logic                   reg_wr_i,
  input  logic [`REG_AW-1:0]     reg_addr_i,
  input  logic [`REG_DW-1:0]     reg_wdata_i,
  input  logic [`REG_DW/8-1:0]   reg_be_i,
  output logic [`REG_DW-1:0]     reg_rdata_o,
  output logic                   reg_ack_o,
  // Pads
  input  pinmux_pkg::gpio_word_t digital_io_in_i,
  output pinmux_pkg::gpio_word_t digital_io_out_o,
  output pinmux_pkg::gpio_word_t digital_io_oen_o,
  // Interrupt and ms tick
  output logic                   irq_o,
  output logic                   pulse1m_mclk_o
);

  import pinmux_pkg::*;

  gpio_word_t                    gpio_in;
  gpio_word_t                    gpio_int_event;
  gpio_word_t                    cfg_gpio_dir;
  gpio_word_t                    cfg_gpio_out;
  gpio_word_t                    cfg_posedge_sel;
  gpio_word_t                    cfg_negedge_sel;
  logic [`PWM_CHANNELS-1:0]      cfg_pwm_enb;
  pwm_cfg_u [`PWM_CHANNELS-1:0]  cfg_pwm;
  logic [`PWM_CHANNELS-1:0]      pwm_wfm;
  logic [`PULSE_CNT_W-1:0]       cfg_pulse_1us;
  logic                          pulse_cfg_update;

  pinmux_reg u_pinmux_reg (
    .mclk               (mclk),
    .reset_i            (reset_i),
    .reg_cs_i           (reg_cs_i),
    .reg_wr_i           (reg_wr_i),
    .reg_addr_i         (reg_addr_i),
    .reg_wdata_i        (reg_wdata_i),
    .reg_be_i           (reg_be_i),
    .reg_rdata_o        (reg_rdata_o),
    .reg_ack_o          (reg_ack_o),
    .gpio_in_i          (gpio_in),
    .gpio_int_event_i   (gpio_int_event),
    .cfg_gpio_dir_o     (cfg_gpio_dir),
    .cfg_gpio_out_o     (cfg_gpio_out),
    .cfg_posedge_sel_o  (cfg_posedge_sel),
    .cfg_negedge_sel_o  (cfg_negedge_sel),
    .cfg_pwm_enb_o      (cfg_pwm_enb),
    .cfg_pwm_o          (cfg_pwm),
    .cfg_pulse_1us_o    (cfg_pulse_1us),
    .pulse_cfg_update_o (pulse_cfg_update),
    .irq_o              (irq_o)
  );

  // us strobe only feeds the ms divider inside
  tick_gen u_tick_gen (
    .mclk            (mclk),
    .reset_i         (reset_i),
    .cfg_pulse_1us_i (cfg_pulse_1us),
    .cfg_update_i    (pulse_cfg_update),
    .pulse_1us_o     (),
    .pulse_1ms_o     (pulse1m_mclk_o)
  );

  gpio_intr_gen u_gpio_intr (
    .mclk              (mclk),
    .reset_i           (reset_i),
    .pad_in_i          (digital_io_in_i),
    .cfg_gpio_dir_i    (cfg_gpio_dir),
    .cfg_gpio_out_i    (cfg_gpio_out),
    .cfg_posedge_sel_i (cfg_posedge_sel),
    .cfg_negedge_sel_i (cfg_negedge_sel),
    .gpio_in_o         (gpio_in),
    .gpio_int_event_o  (gpio_int_event)
  );

  // --------------------------------------------------
  // PWM channels, all paced by the ms tick
  // --------------------------------------------------
  for (genvar ch = 0; ch < `PWM_CHANNELS; ch++) begin : g_pwm
    pwm u_pwm (
      .mclk        (mclk),
      .reset_i     (reset_i),
      .pulse_1ms_i (pulse1m_mclk_o),
      .cfg_enb_i   (cfg_pwm_enb[ch]),
      .cfg_i       (cfg_pwm[ch]),
      .waveform_o  (pwm_wfm[ch])
    );
  end

  pad_mux u_pad_mux (
    .pwm_wfm_i      (pwm_wfm),
    .cfg_pwm_enb_i  (cfg_pwm_enb),
    .cfg_gpio_dir_i (cfg_gpio_dir),
    .cfg_gpio_out_i (cfg_gpio_out),
    .pad_out_o      (digital_io_out_o),
    .pad_oen_o      (digital_io_oen_o)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam time HALF_PERIOD = 50ns;
  localparam int  RESET_CYCLES = 16;

  // Free running 100 ns clock
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset held high for the first cycles, released on an edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== sim/tb_pinmux.sv ====
`timescale 1ns/1ps
`include "pinmux_settings.svh"

module tb_pinmux;

  localparam int CYCLE_LIMIT = 40000;  // Tick and PWM phases dominate

  logic mclk, reset_i, reg_cs_i, reg_wr_i, reg_ack_o, irq_o, pulse1m_mclk_o;
  logic [`REG_AW-1:0]   reg_addr_i;
  logic [`REG_DW-1:0]   reg_wdata_i, reg_rdata_o;
  logic [`REG_DW/8-1:0] reg_be_i;
  logic [`GPIO_WIDTH-1:0] digital_io_in_i, digital_io_out_o, digital_io_oen_o;

  int          cycles, check_cnt, err_cnt, proto_err;
  logic [31:0] shadow [10];           // Expected register contents by word index
  int          rw_idx [8] = '{0, 1, 4, 5, 6, 7, 8, 9};
  logic [31:0] rd, wd, t0, t1;
  logic [7:0]  dir, dout, pad_val;
  logic [3:0]  be;
  int          idx, hi, lo, f_hi, f_lo;

  tb_clk_gen u_clk (.clk_o(mclk), .reset_o(reset_i));

  pinmux_top uut (
    .mclk(mclk), .reset_i(reset_i), .reg_cs_i(reg_cs_i), .reg_wr_i(reg_wr_i),
    .reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i), .reg_be_i(reg_be_i),
    .reg_rdata_o(reg_rdata_o), .reg_ack_o(reg_ack_o),
    .digital_io_in_i(digital_io_in_i), .digital_io_out_o(digital_io_out_o),
    .digital_io_oen_o(digital_io_oen_o), .irq_o(irq_o), .pulse1m_mclk_o(pulse1m_mclk_o)
  );

  // --------------------------------------------------
  // Bus protocol checks
  // --------------------------------------------------
  a_ack_single: assert property (@(posedge mclk) disable iff (reset_i)
                                 reg_ack_o |=> !reg_ack_o)
    else begin
      proto_err++;
      $display("Acknowledge stayed high for more than one cycle at %0t", $time);
    end

  a_ack_needs_cs: assert property (@(posedge mclk) disable iff (reset_i)
                                   !reg_cs_i |=> !reg_ack_o)
    else begin
      proto_err++;
      $display("Acknowledge without a preceding chip select at %0t", $time);
    end

  // Run limit
  always @(posedge mclk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp)
    else begin
      err_cnt++;
      $display("ERROR t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // One access, ack expected at the second falling edge after the request
  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] lanes, output logic [31:0] rdata);
    int n;
    n = 0;
    @(posedge mclk);
    reg_cs_i    <= 1'b1;
    reg_wr_i    <= wr;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    reg_be_i    <= lanes;
    do begin
      @(negedge mclk);
      n++;
    end while (!reg_ack_o && n < 16);
    if (!reg_ack_o) begin
      err_cnt++;
      $display("No acknowledge for access to address 0x%0h", addr);
    end
    check_value("reg_ack_o latency", n, 2);
    rdata = reg_rdata_o;
    @(posedge mclk);
    reg_cs_i <= 1'b0;
    reg_wr_i <= 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, 4'hF, unused);
  endtask

  task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    bus_access(1'b0, addr, '0, 4'hF, got);
    check_value(name, got, exp);
  endtask

  // Implemented bits of each word
  function automatic logic [31:0] reg_mask(input int i);
    case (i)
      6:       return 32'h3;
      7:       return 32'h3FF;
      8, 9:    return 32'hFFFF_FFFF;
      default: return 32'hFF;
    endcase
  endfunction

  // Cycle number of the next ms tick
  task automatic next_tick(output logic [31:0] at);
    do @(negedge mclk); while (!pulse1m_mclk_o);
    at = cycles;
  endtask

  // Ticks seen during one high phase and the following low phase of a pad
  task automatic measure_phases(input int pad, output int n_hi, output int n_lo);
    n_hi = 0;
    n_lo = 0;
    do @(negedge mclk); while (!digital_io_out_o[pad]);
    while (digital_io_out_o[pad]) begin
      if (pulse1m_mclk_o) n_hi++;
      @(negedge mclk);
    end
    while (!digital_io_out_o[pad]) begin
      if (pulse1m_mclk_o) n_lo++;
      @(negedge mclk);
    end
  endtask

  initial begin
    void'($urandom(14259));
    cycles    = 0;
    check_cnt = 0;
    err_cnt   = 0;
    proto_err = 0;
    reg_cs_i        <= 1'b0;
    reg_wr_i        <= 1'b0;
    reg_addr_i      <= '0;
    reg_wdata_i     <= '0;
    reg_be_i        <= '0;
    digital_io_in_i <= '0;
    @(posedge mclk);
    while (reset_i) @(posedge mclk);

    // ------------------------------------------------
    // Reset values, unmapped words, byte merge
    // ------------------------------------------------
    @(negedge mclk);
    check_value("digital_io_oen_o", digital_io_oen_o, 32'hFF);
    check_value("irq_o", irq_o, 0);
    for (int i = 0; i < 10; i++) shadow[i] = '0;
    shadow[7] = `PULSE_1US_RST;
    for (int i = 0; i < 10; i++) begin
      read_check($sformatf("reg_rdata_o at 0x%02h", i * 4), 8'(i * 4), shadow[i]);
    end
    read_check("unmapped 0x28", 8'h28, 0);
    read_check("unmapped 0x03", 8'h03, 0);
    read_check("unmapped 0xFC", 8'hFC, 0);
    for (int k = 0; k < 24; k++) begin
      idx = rw_idx[$urandom_range(0, 7)];
      wd  = $urandom;
      be  = 4'($urandom);
      bus_access(1'b1, 8'(idx * 4), wd, be, rd);
      for (int b = 0; b < 4; b++) if (be[b]) shadow[idx][8*b +: 8] = wd[8*b +: 8];
      shadow[idx] &= reg_mask(idx);
    end
    foreach (rw_idx[k]) begin
      read_check($sformatf("reg_rdata_o at 0x%02h", rw_idx[k] * 4), 8'(rw_idx[k] * 4),
                 shadow[rw_idx[k]]);
    end
    write_reg(`ADDR_MULTI_FUNC_SEL, 0);
    write_reg(`ADDR_GPIO_POSEDGE_SEL, 0);
    write_reg(`ADDR_GPIO_NEGEDGE_SEL, 0);

    // GPIO output pin map
    repeat (8) begin
      dir  = 8'($urandom);
      dout = 8'($urandom);
      write_reg(`ADDR_GPIO_DIR, dir);
      write_reg(`ADDR_GPIO_OUT, dout);
      check_value("digital_io_out_o", digital_io_out_o, dir & dout);
      check_value("digital_io_oen_o", digital_io_oen_o, 8'(~dir));
    end
    write_reg(`ADDR_GPIO_DIR, 0);
    write_reg(`ADDR_GPIO_OUT, 0);

    // ------------------------------------------------
    // GPIO input and edge interrupts
    // ------------------------------------------------
    pad_val = 8'($urandom);
    @(posedge mclk);
    digital_io_in_i <= pad_val;
    repeat (3) @(posedge mclk);
    read_check("GPIO_IN", `ADDR_GPIO_IN, pad_val);
    digital_io_in_i <= 8'h00;
    repeat (3) @(posedge mclk);
    write_reg(`ADDR_GPIO_INT_STAT, 32'hFF);
    read_check("INT_STAT cleared", `ADDR_GPIO_INT_STAT, 0);
    write_reg(`ADDR_GPIO_POSEDGE_SEL, 32'h04);
    write_reg(`ADDR_GPIO_NEGEDGE_SEL, 32'h40);
    digital_io_in_i <= 8'h08;          // Pin 3 has no edge selected
    repeat (4) @(posedge mclk);
    read_check("INT_STAT unselected pin", `ADDR_GPIO_INT_STAT, 0);
    digital_io_in_i <= 8'h0C;          // Rising pin 2
    repeat (4) @(posedge mclk);
    read_check("INT_STAT rising pin 2", `ADDR_GPIO_INT_STAT, 32'h04);
    check_value("irq_o", irq_o, 1);
    digital_io_in_i <= 8'h00;          // Falling not selected on pin 2
    repeat (4) @(posedge mclk);
    read_check("INT_STAT falling pin 2", `ADDR_GPIO_INT_STAT, 32'h04);
    write_reg(`ADDR_GPIO_INT_STAT, 32'h04);
    repeat (2) @(posedge mclk);
    read_check("INT_STAT after clear", `ADDR_GPIO_INT_STAT, 0);
    check_value("irq_o", irq_o, 0);
    // Output pin 6 watches its own drive
    write_reg(`ADDR_GPIO_OUT, 32'h40);
    write_reg(`ADDR_GPIO_DIR, 32'h40);
    write_reg(`ADDR_GPIO_OUT, 32'h00);
    repeat (3) @(posedge mclk);
    read_check("INT_STAT output pin 6", `ADDR_GPIO_INT_STAT, 32'h40);
    check_value("irq_o", irq_o, 1);
    write_reg(`ADDR_GPIO_INT_STAT, 32'h40);
    write_reg(`ADDR_GPIO_POSEDGE_SEL, 0);
    write_reg(`ADDR_GPIO_NEGEDGE_SEL, 0);

    // ------------------------------------------------
    // Tick spacing with a 2 cycle microsecond
    // ------------------------------------------------
    write_reg(`ADDR_PULSE_1US, 1);
    next_tick(t0);
    repeat (2) begin
      next_tick(t1);
      check_value("pulse1m_mclk_o spacing", t1 - t0, 2 * `US_PER_MS);
      t0 = t1;
    end

    // ------------------------------------------------
    // PWM channels
    // ------------------------------------------------
    // Pad 4 left an input and pad 5 driven high by GPIO
    write_reg(`ADDR_GPIO_DIR, 32'h20);
    write_reg(`ADDR_GPIO_OUT, 32'h20);
    write_reg(`ADDR_PWM0, {16'd2, 16'd3});
    write_reg(`ADDR_MULTI_FUNC_SEL, 1);
    check_value("digital_io_oen_o[4]", digital_io_oen_o[`PWM0_PAD], 0);
    measure_phases(`PWM0_PAD, hi, lo);
    check_value("PWM0 high ticks", hi, 2);
    check_value("PWM0 low ticks", lo, 3);
    write_reg(`ADDR_MULTI_FUNC_SEL, 0);
    @(negedge mclk);
    check_value("digital_io_out_o", digital_io_out_o, 8'h20);
    check_value("digital_io_oen_o", digital_io_oen_o, 8'hDF);
    f_hi = $urandom_range(0, 3);
    f_lo = $urandom_range(0, 3);
    write_reg(`ADDR_PWM1, {16'(f_hi), 16'(f_lo)});
    write_reg(`ADDR_MULTI_FUNC_SEL, 2);
    // Only the PWM low phase can pull the GPIO driven pad 5 low
    measure_phases(`PWM1_PAD, hi, lo);
    check_value("PWM1 high ticks", hi, (f_hi == 0) ? 1 : f_hi);
    check_value("PWM1 low ticks", lo, (f_lo == 0) ? 1 : f_lo);
    write_reg(`ADDR_MULTI_FUNC_SEL, 0);
    @(negedge mclk);
    check_value("digital_io_out_o", digital_io_out_o, 8'h20);
    check_value("digital_io_oen_o", digital_io_oen_o, 8'hDF);

    $display("Checks %0d, value errors %0d, protocol errors %0d",
             check_cnt, err_cnt, proto_err);
    if (err_cnt == 0 && proto_err == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/pinmux_pkg.sv
design/pinmux_reg.sv
design/tick_gen.sv
design/gpio_intr_gen.sv
design/pwm.sv
design/pad_mux.sv
design/pinmux_top.sv
sim/tb_clk_gen.sv
sim/tb_pinmux.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_pinmux -f src.f -o tb_pinmux \
  && ./obj_dir/tb_pinmux > sim.log 2>&1 \
  || { echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
